//--- sim.f
rtl/filt_data_pkg.sv
rtl/decim_pkg.sv
rtl/reg_delay.sv
rtl/tap_delay_line.sv
rtl/outer_tap_path.sv
rtl/inner_tap_path.sv
rtl/decim_combine.sv
rtl/half_filt.sv
tests/half_filt_checker.sv
tests/half_filt_tb.sv

//--- Makefile
# Verilator lint, simulation and clean for the half-band filter
TOP = half_filt_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

obj_dir/half_filt_sim: sim.f rtl/*.sv tests/*.sv
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP) \
		-o half_filt_sim

sim: obj_dir/half_filt_sim
	./obj_dir/half_filt_sim > sim.log 2>&1 || true
	cat sim.log
	grep -qx '>>> PASS' sim.log

clean:
	rm -rf obj_dir sim.log

//--- tests/half_filt_tb.sv
// Testbench for the half-band filter that applies a stimulus table and prints the verdict
`timescale 1ns/1ps

module half_filt_tb;

    localparam int streams = 4;
    localparam int rows    = 8;

    localparam int k_const   = 0;
    localparam int k_impulse = 1; // Nonzero on word 1 of the row only
    localparam int k_alt     = 2; // Full-scale blocks of 8 samples per stream
    localparam int k_random  = 3;
    localparam int g_none    = 0;
    localparam int g_alt     = 1; // One idle cycle after each word
    localparam int g_rand    = 2;

    localparam logic signed [filt_data_pkg::data_w-1:0] full_pos = {1'b0, {19{1'b1}}};
    localparam logic signed [filt_data_pkg::data_w-1:0] full_neg = {1'b1, {19{1'b0}}};

    logic                                    clk;
    logic                                    reset;
    logic signed [filt_data_pkg::data_w-1:0] ind;
    logic                                    ing;
    logic signed [filt_data_pkg::data_w-1:0] outd;
    logic                                    outg;
    logic                                    end_of_test;
    logic                                    report_ready;
    int                                      value_errs;
    int                                      timing_errs;
    int                                      flow_errs;
    int                                      outputs_seen;
    int                                      sat_hits;
    int                                      pending;
    int                                      tb_errs;
    int unsigned                             rng;
    int                                      kind_t  [rows];
    int                                      words_t [rows];
    int                                      gap_t   [rows];
    int                                      rst_t   [rows];
    int                                      level_t [rows];

    half_filt #(.streams(streams)) DUT (
        .clk(clk), .reset(reset), .ind(ind), .ing(ing), .outd(outd), .outg(outg)
    );

    half_filt_checker #(.streams(streams)) u_check (
        .clk(clk), .reset(reset), .ind(ind), .ing(ing), .outd(outd), .outg(outg),
        .end_of_test(end_of_test), .value_errs(value_errs), .timing_errs(timing_errs),
        .flow_errs(flow_errs), .outputs_seen(outputs_seen), .sat_hits(sat_hits),
        .pending(pending), .report_ready(report_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic int unsigned lcg_step(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic set_row(input int r, kind, words, gap, rst, level);
        kind_t[r]  = kind;
        words_t[r] = words;
        gap_t[r]   = gap;
        rst_t[r]   = rst;
        level_t[r] = level;
    endtask

    function automatic int total_words();
        int sum;
        sum = 0;
        for (int r = 0; r < rows; r++) sum += words_t[r];
        return sum;
    endfunction

    // Each reset section keeps every second group of one word per stream
    function automatic int expected_pulses();
        int pulses;
        int sec;
        pulses = 0;
        sec    = 0;
        for (int r = 0; r < rows; r++) begin
            if (rst_t[r] != 0) begin
                pulses += (sec / streams / 2) * streams;
                sec = 0;
            end
            sec += words_t[r];
        end
        return pulses + (sec / streams / 2) * streams;
    endfunction

    task automatic idle(input int n);
        ing = 1'b0;
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic apply_reset();
        ing   = 1'b0;
        reset = 1'b1;
        repeat (5) @(posedge clk);
        #1 reset = 1'b0;
        idle(3); // outg must stay low here
    endtask

    task automatic run_row(input int r);
        logic signed [filt_data_pkg::data_w-1:0] data;
        if (rst_t[r] != 0) begin
            if (r != 0) begin
                idle(8); // Let the pipeline drain first
            end
            apply_reset();
        end
        for (int w = 0; w < words_t[r]; w++) begin
            case (kind_t[r])
                k_const:   data = level_t[r];
                k_impulse: data = (w == 1) ? level_t[r] : 0;
                k_alt:     data = ((w / streams / 8) % 2 == 0) ? full_pos : full_neg;
                default: begin
                    rng  = lcg_step(rng);
                    data = $signed(rng[31:12]);
                end
            endcase
            ind = data;
            ing = 1'b1;
            @(posedge clk);
            #1 ing = 1'b0;
            if (gap_t[r] == g_alt) begin
                idle(1);
            end else if (gap_t[r] == g_rand) begin
                rng = lcg_step(rng);
                idle((rng >> 29) % 3);
            end
        end
    endtask

    // Watchdog sized from the stimulus table
    initial begin
        int budget;
        #1;
        budget = total_words() * 3 + 200;
        repeat (budget) @(posedge clk);
        $display("Timeout after %0d cycles, the run did not finish", budget);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        int want;
        reset       = 1'b1;
        ing         = 1'b0;
        ind         = '0;
        end_of_test = 1'b0;
        tb_errs     = 0;
        rng         = 2990;
        set_row(0, k_const,   64,  g_none, 1, 0);       // Fills the delay line
        set_row(1, k_impulse, 64,  g_none, 0, 65536);
        set_row(2, k_const,   64,  g_none, 0, 100000);  // DC gain
        set_row(3, k_const,   48,  g_alt,  0, -77777);
        set_row(4, k_alt,     96,  g_none, 0, 0);       // Drives saturation
        set_row(5, k_random,  128, g_rand, 0, 0);
        set_row(6, k_random,  64,  g_rand, 1, 0);       // Reset mid-run
        set_row(7, k_impulse, 64,  g_alt,  0, -200000);
        for (int r = 0; r < rows; r++) run_row(r);
        idle(8);
        for (int i = 0; i < 20 && pending != 0; i++) idle(1);
        end_of_test = 1'b1;
        idle(1);
        end_of_test = 1'b0;
        want = expected_pulses();
        if (!report_ready) begin
            tb_errs++;
            $display("Checker gave no closing report");
        end
        if (outputs_seen != want) begin
            tb_errs++;
            $display("Saw %0d output pulses where the table gives %0d", outputs_seen, want);
        end
        if (sat_hits == 0) begin
            tb_errs++;
            $display("No kept output reached the saturation limit");
        end
        $display("Errors: value %0d, timing %0d, flow %0d, testbench %0d",
                 value_errs, timing_errs, flow_errs, tb_errs);
        if (value_errs + timing_errs + flow_errs + tb_errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- tests/half_filt_checker.sv
// Scoreboard for the half-band filter, models taps and decimation and checks every output word
`timescale 1ns/1ps

module half_filt_checker #(
    parameter int streams = 4
) (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic signed [filt_data_pkg::data_w-1:0] ind,
    input  logic                                    ing,
    input  logic signed [filt_data_pkg::data_w-1:0] outd,
    input  logic                                    outg,
    input  logic                                    end_of_test,
    output int                                      value_errs,
    output int                                      timing_errs,
    output int                                      flow_errs,
    output int                                      outputs_seen,
    output int                                      sat_hits,
    output int                                      pending,
    output logic                                    report_ready
);

    // Final sum range, 22 bits signed
    localparam longint sat_max = (longint'(1) <<< (filt_data_pkg::data_w + 1)) - 1;
    localparam longint sat_min = -(longint'(1) <<< (filt_data_pkg::data_w + 1));

    longint            hist[$];      // Every accepted word, all streams interleaved
    longint            exp_val[$];
    int                exp_cyc[$];   // Cycle of the word behind each result
    bit                exp_known[$]; // Taps fully defined for this result
    int                cyc;
    int                cnt;
    decim_pkg::phase_t phase;

    // Power-of-two coefficients, floor shifts, +1 rounding before the final >>2
    function automatic longint filter_sum(input longint t0, t2, t4, t5, t6, t8, t10);
        longint s1;
        longint s2;
        longint s3;
        longint outer;
        longint inner;
        s1 = t0 + t10;
        s2 = t2 + t8;
        s3 = t4 + t6;
        outer = (s1 >>> 4) - ((s2 >>> 2) + (s2 >>> 5));
        inner = (s3 >>> 2) - (s3 >>> 5) + s3 + 2 * t5 + 1;
        return outer + inner;
    endfunction

    // Same stream, k samples back
    function automatic longint past_word(input int k);
        return hist[hist.size() - 1 - k * streams];
    endfunction

    initial begin
        value_errs   = 0;
        timing_errs  = 0;
        flow_errs    = 0;
        outputs_seen = 0;
        sat_hits     = 0;
        pending      = 0;
        report_ready = 1'b0;
        cyc          = 0;
        cnt          = 0;
        phase        = decim_pkg::PHASE_DROP;
    end

    always @(posedge clk) begin
        longint                          sum;
        longint                          v;
        logic signed [filt_data_pkg::data_w-1:0] ev;
        int                              wc;
        bit                              known;
        cyc++;
        if (outg === 1'b1) begin
            outputs_seen++;
            if (exp_val.size() == 0) begin
                flow_errs++;
                $display("Output pulse at %0t while no result was expected", $time);
            end else begin
                v     = exp_val.pop_front();
                wc    = exp_cyc.pop_front();
                known = exp_known.pop_front();
                ev    = v[filt_data_pkg::data_w-1:0];
                if (cyc - wc != 4) begin
                    timing_errs++;
                    $display("Result at %0t came %0d cycles after its word instead of 4",
                             $time, cyc - wc);
                end
                if (known && outd !== ev) begin
                    value_errs++;
                    $display("FAIL time %0t signal outd expected %0d actual %0d",
                             $time, ev, outd);
                end
            end
        end
        if (reset === 1'b1) begin
            cnt   = 0;                       // Delay history survives reset
            phase = decim_pkg::PHASE_DROP;
        end else if (ing === 1'b1) begin
            hist.push_back(ind);
            if (phase == decim_pkg::PHASE_KEEP) begin
                known = hist.size() > 10 * streams;
                sum   = 0;
                if (known) begin
                    sum = filter_sum(past_word(0), past_word(2), past_word(4), past_word(5),
                                     past_word(6), past_word(8), past_word(10));
                end
                if (sum > sat_max || sum < sat_min) begin
                    sum = (sum > sat_max) ? sat_max : sat_min;
                    sat_hits++;
                end
                exp_val.push_back(sum >>> 2);
                exp_cyc.push_back(cyc);
                exp_known.push_back(known);
            end
            if (cnt == streams - 1) begin
                cnt   = 0;
                phase = (phase == decim_pkg::PHASE_KEEP) ? decim_pkg::PHASE_DROP
                                                         : decim_pkg::PHASE_KEEP;
            end else begin
                cnt++;
            end
        end
        pending = exp_val.size();
        if (end_of_test === 1'b1 && !report_ready) begin
            if (pending != 0) begin
                flow_errs += pending;
                $display("%0d expected results never appeared on outd", pending);
            end
            report_ready = 1'b1;
        end
    end

endmodule

//--- rtl/half_filt.sv
// Top level of the interleaved half-band decimating filter with a latency of four cycles
`timescale 1ns/1ps

module half_filt #(
    parameter int streams = 4 // Interleaved streams on ind
) (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic signed [filt_data_pkg::data_w-1:0] ind,
    input  logic                                    ing,
    output logic signed [filt_data_pkg::data_w-1:0] outd,
    output logic                                    outg
);

    logic signed [filt_data_pkg::data_w-1:0] tap_0, tap_2, tap_4, tap_5, tap_6, tap_8, tap_10;
    logic signed [filt_data_pkg::part_w-1:0] outer_sum;
    logic signed [filt_data_pkg::part_w-1:0] inner_sum;
    logic                                    outer_g;
    logic                                    inner_g;

    // Odd taps carry zero coefficients
    tap_delay_line #(.streams(streams)) u_taps (
        .clk(clk), .reset(reset), .ing(ing), .ind(ind),
        .tap_0(tap_0), .tap_1(), .tap_2(tap_2), .tap_3(),
        .tap_4(tap_4), .tap_5(tap_5), .tap_6(tap_6), .tap_7(),
        .tap_8(tap_8), .tap_9(), .tap_10(tap_10)
    );

    outer_tap_path u_outer (
        .clk(clk), .reset(reset), .ing(ing),
        .tap_0(tap_0), .tap_2(tap_2), .tap_8(tap_8), .tap_10(tap_10),
        .outer_sum(outer_sum), .outer_g(outer_g)
    );

    inner_tap_path u_inner (
        .clk(clk), .reset(reset), .ing(ing),
        .tap_4(tap_4), .tap_5(tap_5), .tap_6(tap_6),
        .inner_sum(inner_sum), .inner_g(inner_g)
    );

    // inner_g is the common gate of the two equal-latency paths
    decim_combine #(.streams(streams)) u_combine (
        .clk(clk), .reset(reset), .part_g(inner_g),
        .outer_sum(outer_sum), .inner_sum(inner_sum),
        .outd(outd), .outg(outg)
    );

    a_gates_match: assert property (
        @(posedge clk) disable iff (reset)
        outer_g == inner_g
    ) else $error("tap path gates out of step");

endmodule

//--- rtl/decim_combine.sv
// Output stage of the half-band filter, saturating final add and keep/drop decimation of groups
`timescale 1ns/1ps

module decim_combine #(
    parameter int streams = 4 // Counter limit
) (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    part_g,
    input  logic signed [filt_data_pkg::part_w-1:0] outer_sum,
    input  logic signed [filt_data_pkg::part_w-1:0] inner_sum,
    output logic signed [filt_data_pkg::data_w-1:0] outd,
    output logic                                    outg
);

    localparam int sw = filt_data_pkg::sat_w;
    localparam int pw = filt_data_pkg::part_w;

    logic signed [pw:0]                  full_sum; // One bit beyond the partial sums
    logic signed [sw-1:0]                sat_sum;
    logic signed [sw-1:0]                sat_r;
    logic                                keep_g;
    logic [decim_pkg::cnt_w-1:0]         cnt;      // Stream index of the next partial sum
    decim_pkg::phase_t                   phase;

    assign full_sum = outer_sum + inner_sum;

    // Clamp to sw bits when the top bits disagree
    always_comb begin
        if (full_sum[pw:sw-1] == '0 || full_sum[pw:sw-1] == '1) begin
            sat_sum = full_sum[sw-1:0];
        end else if (full_sum[pw]) begin
            sat_sum = {1'b1, {(sw-1){1'b0}}}; // Most negative
        end else begin
            sat_sum = {1'b0, {(sw-1){1'b1}}}; // Most positive
        end
    end

    always_ff @(posedge clk) begin
        sat_r <= sat_sum;
        outd  <= sat_r[sw-1:2];
    end

    // Stream count and keep/drop phase
    always_ff @(posedge clk) begin
        if (reset) begin
            cnt    <= '0;
            phase  <= decim_pkg::PHASE_DROP;
            keep_g <= 1'b0;
            outg   <= 1'b0;
        end else begin
            keep_g <= part_g && (phase == decim_pkg::PHASE_KEEP);
            outg   <= keep_g;
            if (part_g) begin
                if (cnt == streams - 1) begin
                    cnt   <= '0;
                    phase <= (phase == decim_pkg::PHASE_KEEP) ?
                             decim_pkg::PHASE_DROP : decim_pkg::PHASE_KEEP; // Toggle per group
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    a_cnt_range: assert property (
        @(posedge clk) disable iff (reset)
        cnt < streams
    ) else $error("stream counter out of range");

    // Every output must come from a partial sum seen in a keep group
    a_keep_only: assert property (
        @(posedge clk) disable iff (reset)
        outg |-> $past(part_g && (phase == decim_pkg::PHASE_KEEP), 2)
    ) else $error("outg from a dropped group");

endmodule

//--- rtl/inner_tap_path.sv
// Inner coefficient path of the half-band filter, two-cycle partial sum of taps 4/6 and centre tap 5
`timescale 1ns/1ps

module inner_tap_path (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    ing,
    input  logic signed [filt_data_pkg::data_w-1:0] tap_4,
    input  logic signed [filt_data_pkg::data_w-1:0] tap_5,
    input  logic signed [filt_data_pkg::data_w-1:0] tap_6,
    output logic signed [filt_data_pkg::part_w-1:0] inner_sum,
    output logic                                    inner_g
);

    logic signed [filt_data_pkg::pair_w-1:0]   s3;   // t4 + t6
    logic signed [filt_data_pkg::pair_w-1:0]   s4;   // Centre tap, widened
    logic                                      sg;
    logic signed [filt_data_pkg::scaled_w-1:0] a3;
    logic signed [filt_data_pkg::scaled_w-1:0] a4;

    // Stage 1
    always_ff @(posedge clk) begin
        s3 <= tap_4 + tap_6;
        s4 <= tap_5;
    end

    // This gate also drives the combiner
    always_ff @(posedge clk) begin
        if (reset) begin
            sg      <= 1'b0;
            inner_g <= 1'b0;
        end else begin
            sg      <= ing;
            inner_g <= sg;
        end
    end

    // 1/4 - 1/32 on the pair
    assign a3 = (s3 >>> 2) - (s3 >>> 5);

    // Unit weight on the pair, twice the centre tap
    assign a4 = s3 + (s4 <<< 1);

    // Stage 2, the extra 1 is the rounding offset
    // for the final >>2 taken on the output
    always_ff @(posedge clk) begin
        inner_sum <= a3 + a4 + 1;
    end

endmodule

//--- rtl/outer_tap_path.sv
// Outer coefficient path of the half-band filter, two-cycle partial sum of taps 0/10 and 2/8
`timescale 1ns/1ps

module outer_tap_path (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    ing,
    input  logic signed [filt_data_pkg::data_w-1:0] tap_0,
    input  logic signed [filt_data_pkg::data_w-1:0] tap_2,
    input  logic signed [filt_data_pkg::data_w-1:0] tap_8,
    input  logic signed [filt_data_pkg::data_w-1:0] tap_10,
    output logic signed [filt_data_pkg::part_w-1:0] outer_sum,
    output logic                                    outer_g
);

    logic signed [filt_data_pkg::pair_w-1:0]   s1;   // t0 + t10
    logic signed [filt_data_pkg::pair_w-1:0]   s2;   // t2 + t8
    logic                                      sg;   // Gate for stage 1
    logic signed [filt_data_pkg::scaled_w-1:0] a1;
    logic signed [filt_data_pkg::scaled_w-1:0] a2;

    // Stage 1, symmetric pair sums
    always_ff @(posedge clk) begin
        s1 <= tap_0 + tap_10;
        s2 <= tap_2 + tap_8;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sg      <= 1'b0;
            outer_g <= 1'b0;
        end else begin
            sg      <= ing;
            outer_g <= sg;
        end
    end

    // Coefficients 1/16 and -(1/4 + 1/32), floor rounding
    assign a1 = s1 >>> 4;
    assign a2 = (s2 >>> 2) + (s2 >>> 5);

    // Stage 2, outer partial sum
    always_ff @(posedge clk) begin
        outer_sum <= a1 - a2;
    end

    a_outer_gate: assert property (
        @(posedge clk) disable iff (reset)
        outer_g |-> $past(ing, 2)
    ) else $error("outer_g without a gated word two cycles earlier");

endmodule

//--- rtl/tap_delay_line.sv
// Ten gated delay stages giving taps 0 to 10 of the same stream for the interleaved filter
`timescale 1ns/1ps

module tap_delay_line #(
    parameter int streams = 4 // Interleaved streams, sets each stage length
) (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    ing,
    input  logic signed [filt_data_pkg::data_w-1:0] ind,
    output logic signed [filt_data_pkg::data_w-1:0] tap_0,
    output logic signed [filt_data_pkg::data_w-1:0] tap_1,
    output logic signed [filt_data_pkg::data_w-1:0] tap_2,
    output logic signed [filt_data_pkg::data_w-1:0] tap_3,
    output logic signed [filt_data_pkg::data_w-1:0] tap_4,
    output logic signed [filt_data_pkg::data_w-1:0] tap_5,
    output logic signed [filt_data_pkg::data_w-1:0] tap_6,
    output logic signed [filt_data_pkg::data_w-1:0] tap_7,
    output logic signed [filt_data_pkg::data_w-1:0] tap_8,
    output logic signed [filt_data_pkg::data_w-1:0] tap_9,
    output logic signed [filt_data_pkg::data_w-1:0] tap_10
);

    logic signed [filt_data_pkg::data_w-1:0] chain [0:10];
    logic                                    shift_g;

    assign shift_g  = ing & ~reset; // Line freezes in reset, data kept
    assign chain[0] = ind;          // Tap 0 is the live input

    // Each stage spans one full round of streams
    for (genvar k = 0; k < 10; k++) begin : g_stage
        reg_delay #(
            .dw  (filt_data_pkg::data_w),
            .len (streams)
        ) u_delay (
            .clk   (clk),
            .reset (1'b0),
            .gate  (shift_g),
            .din   (chain[k]),
            .dout  (chain[k+1])
        );
    end

    assign tap_0  = chain[0];
    assign tap_1  = chain[1];
    assign tap_2  = chain[2];
    assign tap_3  = chain[3];
    assign tap_4  = chain[4];
    assign tap_5  = chain[5];
    assign tap_6  = chain[6];
    assign tap_7  = chain[7];
    assign tap_8  = chain[8];
    assign tap_9  = chain[9];
    assign tap_10 = chain[10];

endmodule

//--- rtl/reg_delay.sv
// Gated shift register that delays a word by len valid samples, one stage of the tap delay line
`timescale 1ns/1ps

module reg_delay #(
    parameter int dw = 20,  // Word width
    parameter int len = 4   // Delay in gated words
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 gate,
    input  logic signed [dw-1:0] din,
    output logic signed [dw-1:0] dout
);

    logic signed [dw-1:0] sr [len]; // sr[0] newest, sr[len-1] oldest
    logic                 shift_en;

    // Contents are never cleared, only held while reset is high
    assign shift_en = gate & ~reset;

    always_ff @(posedge clk) begin
        if (shift_en) begin
            sr[0] <= din;
            for (int i = 1; i < len; i++) begin
                sr[i] <= sr[i-1];
            end
        end
    end

    assign dout = sr[len-1]; // Oldest word

endmodule

//--- rtl/decim_pkg.sv
// Decimation phase and stream counter width, used by the output combiner and its checker
package decim_pkg;

    // Keep or discard the current group of one output per stream
    typedef enum logic {
        PHASE_DROP, // Group discarded
        PHASE_KEEP  // Group emitted
    } phase_t;

    // Stream counter, up to 512 interleaved streams
    localparam int cnt_w = 9;

endpackage

//--- rtl/filt_data_pkg.sv
// Word widths of the half-band filter data path, used by the delay line, tap paths and combiner
package filt_data_pkg;

    // Input and output samples
    localparam int data_w = 20;

    // Sum of two taps, one guard bit
    localparam int pair_w = data_w + 1;

    // Scaled or doubled tap-pair term
    localparam int scaled_w = pair_w + 1;

    // Outer and inner partial sums
    localparam int part_w = scaled_w + 1;

    // Width after the final add is saturated, the output takes its top data_w bits
    localparam int sat_w = part_w - 1;

endpackage
